/* bench/cpu_tb.sv */
/*
  Top-level testbench for the five-stage core. Runs the fixed program
  held in the bench memory, checks every store, the skipped stores, the
  Wishbone handshake and the halt with concurrent assertions, and waits
  for halted under a cycle limit.
*/
`timescale 1ns/100ps

module cpu_tb;
  import rv_isa_pkg::*;

  localparam int    program_words = 30;
  localparam int    max_cycles    = 10 * (program_words + 10);  // Waits, bus turnaround, flushes
  localparam int    store_count   = 9;                           // SWs on the executed path
  localparam word_t poison_base   = 32'h0000_01f0;               // Targets of skipped SWs only
  localparam word_t boot_pc       = 32'h0000_0000;               // First fetch address

  logic  clk;
  logic  reset;
  word_t imem_addr, imem_data, wb_adr, wb_dat_w, wb_dat_r;
  logic  wb_cyc, wb_stb, wb_we, wb_ack, halted;
  int    cycle;
  int    write_count;

  pipeline_cpu dut0 (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .halted(halted)
  );

  tb_memory mem0 (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  // Values worked out by hand from the program constants
  function automatic word_t expected_store(input word_t addr);
    case (addr)
      32'h100: return 32'h0000_002b;  // 25 + 18
      32'h104: return 32'hffff_ffe7;  // 18 - 43
      32'h108: return 32'h0000_0023;  // -25 & 43
      32'h10c: return 32'h0000_0033;  // 0x23 | 0x12
      32'h110: return 32'hffff_ffd4;  // 0x33 ^ -25
      32'h114: return 32'h0000_0001;  // -44 < 51 signed
      32'h118: return 32'h0000_003d;  // Loaded 43 plus 18
      32'h11c: return 32'h0000_0033;
      32'h120: return 32'h0000_0068;  // JAL at 0x64 plus four
      default: return 'x;             // No store belongs here
    endcase
  endfunction

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    stop_on_failure($sformatf("error: %s expected %h actual %h", name, expected, actual));
  endtask

  always @(posedge clk) begin
    if (reset) begin
      cycle       <= 0;
      write_count <= 0;
    end else begin
      cycle <= cycle + 1;
      if (wb_cyc && wb_we && wb_ack)
        write_count <= write_count + 1;  // Completed bus write
    end
  end

  store_value: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_we && wb_ack |-> wb_dat_w === expected_store(wb_adr))
    else report_mismatch($sformatf("wb_dat_w at %h", $sampled(wb_adr)),
                         expected_store($sampled(wb_adr)), $sampled(wb_dat_w));

  no_poison: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_we |-> wb_adr < poison_base)
    else stop_on_failure($sformatf("skipped store reached the bus at %h", $sampled(wb_adr)));

  // Classic handshake holds everything until ack
  bus_hold: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_stb) && $stable(wb_we) &&
                            $stable(wb_adr) && $stable(wb_dat_w))
    else stop_on_failure("bus signals changed before ack");

  stb_follows_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb == wb_cyc)
    else stop_on_failure("wb_stb and wb_cyc differ");

  idle_after_reset: assert property (@(posedge clk) reset |=> !wb_cyc && !wb_we && !halted)
    else stop_on_failure("bus or halted not idle after reset");

  // Fetch starts from the boot address
  fetch_after_reset: assert property (@(posedge clk) reset |=> imem_addr == boot_pc)
    else report_mismatch("imem_addr", boot_pc, $sampled(imem_addr));

  halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else stop_on_failure("halted dropped before reset");

  halt_quiet: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_cyc)
    else stop_on_failure("bus cycle after halt");

  write_total: assert property (@(posedge clk) disable iff (reset)
      $rose(halted) |-> write_count == store_count)
    else report_mismatch("write_count", store_count, $sampled(write_count));

  initial begin
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    while (!halted && cycle < max_cycles)
      @(negedge clk);
    if (!halted) begin
      stop_on_failure($sformatf("timeout, core did not halt within %0d cycles", max_cycles));
    end else begin
      repeat (4) @(negedge clk);  // Halt must hold with the bus quiet
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* bench/tb_memory.sv */
/*
  Bench memory model for the pipelined core. A combinational program
  ROM serves the fetch port, and a Wishbone classic data RAM acks each
  cycle after 0 to 3 random wait states. Bus outputs move on the falling edge.
*/
`timescale 1ns/100ps

module tb_memory (
  input  logic              clk,
  input  logic              reset,
  input  rv_isa_pkg::word_t imem_addr,
  output rv_isa_pkg::word_t imem_data,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  rv_isa_pkg::word_t wb_adr,
  input  rv_isa_pkg::word_t wb_dat_w,
  output rv_isa_pkg::word_t wb_dat_r,
  output logic              wb_ack
);
  import rv_isa_pkg::*;

  localparam logic [31:0] seed = 32'hec857a60;

  word_t       rom [0:63];
  word_t       ram [0:63];  // Data words 0x100 to 0x1fc
  logic [31:0] rng;         // Low two bits give the wait count
  logic [1:0]  waited;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Instruction formats straight from the RV32I base encoding
  function automatic word_t r_format(input logic [6:0] f7, input funct3_t f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t i_format(input opcode_t opc, input funct3_t f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_format(input reg_addr_t rs2, input reg_addr_t rs1,
                                     input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};  // SW only
  endfunction

  function automatic word_t b_format(input funct3_t f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic word_t j_format(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  initial begin
    for (int a = 0; a < 64; a++) begin
      rom[a] = i_format(opc_op_imm, f3_add_sub, 5'd0, 5'd0, a[11:0]);  // addi x0 NOPs
      ram[a] <= 32'h5a00_0000 | (32'h100 + 4 * a);
    end
    // Dependent arithmetic without gaps
    rom[0]  = i_format(opc_op_imm, f3_add_sub, 5'd1, 5'd0, 12'd25);
    rom[1]  = i_format(opc_op_imm, f3_add_sub, 5'd2, 5'd1, -12'd7);
    rom[2]  = r_format(7'd0, f3_add_sub, 5'd3, 5'd1, 5'd2);
    rom[3]  = r_format(funct7_sub, f3_add_sub, 5'd4, 5'd2, 5'd3);
    rom[4]  = r_format(7'd0, f3_and, 5'd5, 5'd4, 5'd3);
    rom[5]  = r_format(7'd0, f3_or, 5'd6, 5'd5, 5'd2);
    rom[6]  = r_format(7'd0, f3_xor, 5'd7, 5'd6, 5'd4);
    rom[7]  = r_format(7'd0, f3_slt, 5'd8, 5'd7, 5'd6);
    rom[8]  = s_format(5'd8, 5'd0, 12'h114);  // Store data forwarded from memory stage
    rom[9]  = s_format(5'd7, 5'd0, 12'h110);  // and from writeback
    rom[10] = s_format(5'd3, 5'd0, 12'h100);
    rom[11] = s_format(5'd4, 5'd0, 12'h104);
    rom[12] = s_format(5'd5, 5'd0, 12'h108);
    rom[13] = s_format(5'd6, 5'd0, 12'h10c);
    // Load-use pair
    rom[14] = i_format(opc_load, 3'b010, 5'd9, 5'd0, 12'h100);  // lw x9
    rom[15] = r_format(7'd0, f3_add_sub, 5'd10, 5'd9, 5'd2);
    rom[16] = s_format(5'd10, 5'd0, 12'h118);
    // Branches with skipped stores aimed at 0x1f0 and up
    rom[17] = b_format(f3_beq, 5'd1, 5'd1, 13'd12);  // Taken
    rom[18] = s_format(5'd1, 5'd0, 12'h1f0);
    rom[19] = s_format(5'd1, 5'd0, 12'h1f4);
    rom[20] = b_format(f3_bne, 5'd1, 5'd2, 13'd12);  // Taken
    rom[21] = s_format(5'd1, 5'd0, 12'h1f8);
    rom[22] = s_format(5'd1, 5'd0, 12'h1fc);
    rom[23] = b_format(f3_bne, 5'd1, 5'd1, 13'd8);   // Not taken so the next SW runs
    rom[24] = s_format(5'd6, 5'd0, 12'h11c);
    // JAL over two stores, then store the link
    rom[25] = j_format(5'd11, 21'd12);
    rom[26] = s_format(5'd1, 5'd0, 12'h1f0);
    rom[27] = s_format(5'd1, 5'd0, 12'h1f4);
    rom[28] = s_format(5'd11, 5'd0, 12'h120);
    rom[29] = {25'd0, opc_system};  // ECALL
    wb_ack   <= 1'b0;
    wb_dat_r <= '0;
    waited   <= '0;
    rng      <= xorshift(seed);
  end

  assign imem_data = rom[imem_addr[7:2]];

  always @(negedge clk) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      waited   <= '0;
      rng      <= xorshift(seed);
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // One-cycle ack
      waited <= '0;
      rng    <= xorshift(rng);  // Fresh wait count for the next cycle
    end else if (wb_cyc && wb_stb) begin
      if (waited == rng[1:0]) begin
        wb_ack <= 1'b1;
        if (wb_we)
          ram[wb_adr[7:2]] <= wb_dat_w;
        else
          wb_dat_r <= ram[wb_adr[7:2]];
      end else begin
        waited <= waited + 2'd1;  // Wait state
      end
    end
  end

endmodule

/* project.f */
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/decoder.sv
source/register_file.sv
source/hazard_unit.sv
source/execute_alu.sv
source/data_bus_master.sv
source/pipeline_cpu.sv
bench/tb_memory.sv
bench/cpu_tb.sv

/* source/data_bus_master.sv */
/*
  Wishbone classic master for the memory stage. Runs one word read or
  write per request and holds mem_busy until the ack edge, so the
  pipeline stays frozen for the whole access.
*/
`timescale 1ns/100ps

module data_bus_master (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_read,
  input  logic              req_write,
  input  rv_isa_pkg::word_t addr,
  input  rv_isa_pkg::word_t wdata,
  output rv_isa_pkg::word_t rdata,
  output logic              mem_busy,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output rv_isa_pkg::word_t wb_adr,
  output rv_isa_pkg::word_t wb_dat_w,
  input  rv_isa_pkg::word_t wb_dat_r,
  input  logic              wb_ack
);
  typedef enum logic {st_idle, st_wait} state_t;

  state_t state;
  logic   req;
  logic   done;  // High for the cycle after ack

  assign req      = req_read || req_write;
  assign wb_cyc   = (state == st_wait);
  assign wb_stb   = wb_cyc;  // Single transfer per cycle
  assign mem_busy = wb_cyc || (req && !done);  // Request cycle and wait cycles

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      done  <= 1'b0;
      wb_we <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle:
          if (req && !done) begin  // Same request already served
            state    <= st_wait;
            wb_we    <= req_write;
            wb_adr   <= addr;
            wb_dat_w <= wdata;
          end
        st_wait:
          if (wb_ack) begin
            state <= st_idle;
            done  <= 1'b1;
            wb_we <= 1'b0;
            if (!wb_we)
              rdata <= wb_dat_r;  // Load data for writeback
          end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* source/decoder.sv */
/*
  Instruction decoder for the decode stage. Produces control bits,
  the ALU operation and the sign-extended immediate, and flags the
  source registers really read so the hazard logic can ignore the rest.
*/
`timescale 1ns/100ps

module decoder (
  input  rv_isa_pkg::word_t     instr,
  output rv_isa_pkg::word_t     imm,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output pipe_pkg::alu_op_t     alu_op,
  output logic                  use_imm,
  output logic                  reg_write,
  output logic                  mem_read,
  output logic                  mem_write,
  output logic                  is_branch,
  output logic                  branch_ne,
  output logic                  is_jal,
  output logic                  is_ecall,
  output logic                  reads_rs1,
  output logic                  reads_rs2
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic    op_reg, op_imm, op_load, op_store, op_branch;
  word_t   imm_i, imm_s, imm_b, imm_j;

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[funct3_lsb +: 3];
  assign rs1    = instr[rs1_lsb +: reg_addr_w];
  assign rs2    = instr[rs2_lsb +: reg_addr_w];
  assign rd     = instr[rd_lsb +: reg_addr_w];

  // Immediate formats, bit 31 is always the sign
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Unknown opcodes match none of these and decode to a bubble
  assign op_reg    = (opcode == opc_op);
  assign op_imm    = (opcode == opc_op_imm);
  assign op_load   = (opcode == opc_load);
  assign op_store  = (opcode == opc_store);
  assign op_branch = (opcode == opc_branch);
  assign is_jal    = (opcode == opc_jal);
  assign is_ecall  = (opcode == opc_system);  // Any SYSTEM halts

  assign use_imm   = op_imm || op_load || op_store;
  assign reg_write = op_reg || op_imm || op_load || is_jal;
  assign mem_read  = op_load;
  assign mem_write = op_store;
  assign is_branch = op_branch && (funct3 == f3_beq || funct3 == f3_bne);
  assign branch_ne = op_branch && (funct3 == f3_bne);
  assign reads_rs1 = op_reg || op_imm || op_load || op_store || op_branch;
  assign reads_rs2 = op_reg || op_store || op_branch;

  always_comb begin
    case (opcode)
      opc_store:  imm = imm_s;
      opc_branch: imm = imm_b;
      opc_jal:    imm = imm_j;
      default:    imm = imm_i;
    endcase
    alu_op = alu_add;  // Address and default arithmetic
    if (op_reg || op_imm) begin
      case (funct3)
        f3_add_sub: alu_op = (op_reg && instr[funct7_lsb +: 7] == funct7_sub) ? alu_sub : alu_add;
        f3_slt:     alu_op = alu_slt;
        f3_xor:     alu_op = alu_xor;
        f3_or:      alu_op = alu_or;
        f3_and:     alu_op = alu_and;
        default:    alu_op = alu_add;  // Shifts and SLTU not decoded
      endcase
    end
  end

endmodule

/* source/execute_alu.sv */
/*
  Execute stage ALU. Computes the six arithmetic and logic operations
  and the equality test used by BEQ and BNE.
*/
`timescale 1ns/100ps

module execute_alu (
  input  pipe_pkg::alu_op_t alu_op,
  input  rv_isa_pkg::word_t operand_a,
  input  rv_isa_pkg::word_t operand_b,
  input  logic              branch_ne,
  output rv_isa_pkg::word_t result,
  output logic              branch_cond
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  always_comb begin
    case (alu_op)
      alu_add: result = operand_a + operand_b;
      alu_sub: result = operand_a - operand_b;
      alu_and: result = operand_a & operand_b;
      alu_or:  result = operand_a | operand_b;
      alu_xor: result = operand_a ^ operand_b;
      alu_slt: result = word_t'($signed(operand_a) < $signed(operand_b));
      default: result = operand_a + operand_b;
    endcase
  end

  // Equal for BEQ, flipped for BNE
  assign branch_cond = (operand_a == operand_b) ^ branch_ne;

endmodule

/* source/hazard_unit.sv */
/*
  Forwarding selection for the two execute operands and load-use
  stall detection for the decode stage. Purely combinational.
*/
`timescale 1ns/100ps

module hazard_unit (
  input  rv_isa_pkg::reg_addr_t ex_rs1,
  input  rv_isa_pkg::reg_addr_t ex_rs2,
  input  rv_isa_pkg::reg_addr_t mem_rd,
  input  logic                  mem_reg_write,
  input  rv_isa_pkg::reg_addr_t wb_rd,
  input  logic                  wb_reg_write,
  input  rv_isa_pkg::reg_addr_t id_rs1,
  input  rv_isa_pkg::reg_addr_t id_rs2,
  input  logic                  id_reads_rs1,
  input  logic                  id_reads_rs2,
  input  rv_isa_pkg::reg_addr_t ex_rd,
  input  logic                  ex_mem_read,
  output pipe_pkg::fwd_sel_t    fwd_a,
  output pipe_pkg::fwd_sel_t    fwd_b,
  output logic                  load_use_stall
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  // Memory stage is younger so it is checked first
  function automatic fwd_sel_t pick_source(input reg_addr_t src);
    if (src == '0)
      return fwd_from_reg;  // x0 is never forwarded
    if (mem_reg_write && mem_rd == src)
      return fwd_from_mem;
    if (wb_reg_write && wb_rd == src)
      return fwd_from_wb;
    return fwd_from_reg;
  endfunction

  always_comb begin
    fwd_a = pick_source(ex_rs1);
    fwd_b = pick_source(ex_rs2);
  end

  // Load data arrives only after the memory stage, one bubble covers it
  assign load_use_stall = ex_mem_read && ex_rd != '0 &&
                          ((id_reads_rs1 && id_rs1 == ex_rd) ||
                           (id_reads_rs2 && id_rs2 == ex_rd));

endmodule

/* source/pipe_pkg.sv */
/*
  Microarchitecture definitions for the five-stage core.
  ALU operation codes, forwarding selections and PC constants.
*/
package pipe_pkg;

  // Operation carried from decode into execute
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt    // Signed compare giving 0 or 1
  } alu_op_t;

  // Where an execute operand comes from
  typedef enum logic [1:0] {
    fwd_from_reg,  // Value read in decode
    fwd_from_mem,  // Result sitting in the memory stage
    fwd_from_wb    // Result being written back
  } fwd_sel_t;

  localparam logic [31:0] reset_pc = 32'h0000_0000;
  localparam logic [31:0] pc_step  = 32'd4;  // One instruction word

endpackage

/* source/pipeline_cpu.sv */
/*
  Five-stage pipelined RV32I subset core. Fetch reads an external
  instruction ROM, loads and stores go out over Wishbone classic.
  Branches and JAL resolve in execute and squash the two younger slots.
  A bus wait state freezes every stage, and ECALL halts the core.
*/
`timescale 1ns/100ps

module pipeline_cpu (
  input  logic              clk,
  input  logic              reset,
  output rv_isa_pkg::word_t imem_addr,
  input  rv_isa_pkg::word_t imem_data,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output rv_isa_pkg::word_t wb_adr,
  output rv_isa_pkg::word_t wb_dat_w,
  input  rv_isa_pkg::word_t wb_dat_r,
  input  logic              wb_ack,
  output logic              halted
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  word_t     pc;
  logic      fetch_stop;  // Set once an ECALL leaves execute
  // Decode stage
  logic      id_valid;
  word_t     id_pc, id_instr, dec_imm, rs1_data, rs2_data;
  reg_addr_t dec_rs1, dec_rs2, dec_rd;
  alu_op_t   dec_alu_op;
  logic      dec_use_imm, dec_reg_write, dec_mem_read, dec_mem_write;
  logic      dec_is_branch, dec_branch_ne, dec_is_jal, dec_is_ecall;
  logic      dec_reads_rs1, dec_reads_rs2;
  // Execute stage
  logic      ex_valid;
  word_t     ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
  reg_addr_t ex_rs1, ex_rs2, ex_rd;
  alu_op_t   ex_alu_op;
  logic      ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
  logic      ex_is_branch, ex_branch_ne, ex_is_jal, ex_is_ecall;
  fwd_sel_t  fwd_a, fwd_b;
  word_t     operand_a, operand_b, store_data, alu_result;
  logic      load_use_stall, branch_cond, redirect, squash;
  // Memory stage
  logic      mem_valid, mem_busy;
  word_t     mem_pc, mem_alu, mem_store_data, mem_fwd, load_data;
  reg_addr_t mem_rd;
  logic      mem_reg_write, mem_is_load, mem_is_store, mem_is_jal, mem_is_ecall;
  // Writeback stage
  logic      wr_valid;
  word_t     wr_pc, wr_alu, wr_load, wr_data;
  reg_addr_t wr_rd;
  logic      wr_reg_write, wr_is_load, wr_is_jal, wr_is_ecall;

  assign imem_addr = pc;
  assign redirect  = ex_valid && ((ex_is_branch && branch_cond) || ex_is_jal);
  assign squash    = redirect || (ex_valid && ex_is_ecall);  // Kill fetch and decode slots

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= reset_pc;
      fetch_stop <= 1'b0;
    end else if (!mem_busy) begin
      if (redirect)
        pc <= ex_pc + ex_imm;  // Branch or JAL target
      else if (!load_use_stall && !fetch_stop)
        pc <= pc + pc_step;
      if (ex_valid && ex_is_ecall)
        fetch_stop <= 1'b1;
    end
  end

  // IF/ID holds during a load-use stall
  always_ff @(posedge clk) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (!mem_busy && !load_use_stall) begin
      id_valid <= !squash && !fetch_stop;
      id_pc    <= pc;
      id_instr <= imem_data;
    end
  end

  decoder dec0 (
    .instr(id_instr), .imm(dec_imm), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
    .alu_op(dec_alu_op), .use_imm(dec_use_imm), .reg_write(dec_reg_write),
    .mem_read(dec_mem_read), .mem_write(dec_mem_write), .is_branch(dec_is_branch),
    .branch_ne(dec_branch_ne), .is_jal(dec_is_jal), .is_ecall(dec_is_ecall),
    .reads_rs1(dec_reads_rs1), .reads_rs2(dec_reads_rs2)
  );

  // Register file sits beside decode and is written from writeback
  register_file rf0 (
    .clk(clk), .reset(reset), .rs1_addr(dec_rs1), .rs2_addr(dec_rs2),
    .rd_addr(wr_rd), .rd_data(wr_data), .write_en(wr_valid && wr_reg_write && !mem_busy),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // ID/EX takes a bubble on squash or load-use stall
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (!mem_busy) begin
      ex_valid  <= id_valid && !squash && !load_use_stall;
      ex_alu_op <= dec_alu_op;
      {ex_pc, ex_imm, ex_rs1_data, ex_rs2_data} <= {id_pc, dec_imm, rs1_data, rs2_data};
      {ex_rs1, ex_rs2, ex_rd} <= {dec_rs1, dec_rs2, dec_rd};
      {ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write} <=
        {dec_use_imm, dec_reg_write, dec_mem_read, dec_mem_write};
      {ex_is_branch, ex_branch_ne, ex_is_jal, ex_is_ecall} <=
        {dec_is_branch, dec_branch_ne, dec_is_jal, dec_is_ecall};
    end
  end

  hazard_unit hz0 (
    .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
    .mem_rd(mem_rd), .mem_reg_write(mem_valid && mem_reg_write),
    .wb_rd(wr_rd), .wb_reg_write(wr_valid && wr_reg_write),
    .id_rs1(dec_rs1), .id_rs2(dec_rs2),
    .id_reads_rs1(id_valid && dec_reads_rs1), .id_reads_rs2(id_valid && dec_reads_rs2),
    .ex_rd(ex_rd), .ex_mem_read(ex_valid && ex_mem_read),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .load_use_stall(load_use_stall)
  );

  // Results ahead of execute, JAL forwards its link address
  assign mem_fwd = mem_is_jal ? mem_pc + pc_step : mem_alu;
  assign wr_data = wr_is_load ? wr_load : (wr_is_jal ? wr_pc + pc_step : wr_alu);

  function automatic word_t fwd_value(input fwd_sel_t sel, input word_t from_reg);
    case (sel)
      fwd_from_mem: return mem_fwd;
      fwd_from_wb:  return wr_data;
      default:      return from_reg;
    endcase
  endfunction

  always_comb begin
    operand_a  = fwd_value(fwd_a, ex_rs1_data);
    store_data = fwd_value(fwd_b, ex_rs2_data);  // Also the SW data
  end
  assign operand_b = ex_use_imm ? ex_imm : store_data;

  execute_alu alu0 (
    .alu_op(ex_alu_op), .operand_a(operand_a), .operand_b(operand_b),
    .branch_ne(ex_branch_ne), .result(alu_result), .branch_cond(branch_cond)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
    end else if (!mem_busy) begin
      mem_valid <= ex_valid;
      {mem_pc, mem_alu, mem_store_data, mem_rd} <= {ex_pc, alu_result, store_data, ex_rd};
      {mem_reg_write, mem_is_load, mem_is_store, mem_is_jal, mem_is_ecall} <=
        {ex_reg_write, ex_mem_read, ex_mem_write, ex_is_jal, ex_is_ecall};
    end
  end

  data_bus_master bus0 (
    .clk(clk), .reset(reset),
    .req_read(mem_valid && mem_is_load), .req_write(mem_valid && mem_is_store),
    .addr(mem_alu), .wdata(mem_store_data), .rdata(load_data), .mem_busy(mem_busy),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      if (!mem_busy) begin
        wr_valid <= mem_valid;
        {wr_pc, wr_alu, wr_load, wr_rd} <= {mem_pc, mem_alu, load_data, mem_rd};
        {wr_reg_write, wr_is_load, wr_is_jal, wr_is_ecall} <=
          {mem_reg_write, mem_is_load, mem_is_jal, mem_is_ecall};
      end
      if (wr_valid && wr_is_ecall)
        halted <= 1'b1;  // Sticky until reset
    end
  end

endmodule

/* source/register_file.sv */
/*
  Integer register file with 31 writable words and x0 tied to zero.
  Written at the edge from writeback. Both read ports are combinational
  and return a same-cycle write to the addressed register.
*/
`timescale 1ns/100ps

module register_file (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::reg_addr_t rd_addr,
  input  rv_isa_pkg::word_t     rd_data,
  input  logic                  write_en,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  word_t regs [1:31];  // No storage for x0

  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    if (write_en && addr == rd_addr)
      return rd_data;  // Writeback bypass into decode
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (write_en && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

/* source/rv_isa_pkg.sv */
/*
  Instruction set definitions for the RV32I subset core.
  Major opcodes, function codes and instruction field positions,
  shared by the decoder, the ALU, the top level and the bench.
*/
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [2:0]            funct3_t;

  // Major opcodes in bits 6:0
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,  // Register-register ALU
    opc_op_imm = 7'b0010011,  // ALU with I immediate
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011   // Only ECALL decoded
  } opcode_t;

  // Field start bits
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;

  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;
  localparam funct3_t f3_beq     = 3'b000;
  localparam funct3_t f3_bne     = 3'b001;

  localparam logic [6:0] funct7_sub = 7'b0100000;  // SUB instead of ADD

endpackage
